//--- source/mpb_bus_pkg.sv
////////////////////////////////////////////////////////////
// Message-passing end-point, bus side definitions
// Request bundle, register map, status bits and FSM states
////////////////////////////////////////////////////////////

package mpb_bus_pkg;

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;

  // AHB-Lite request as seen by the register block
  typedef struct packed {
    logic      sel;
    logic      write;
    bus_addr_t addr;
    bus_data_t wdata;
  } bus_req_t;

  // Word offsets, decoded from address bits 5:2
  localparam int REG_IDX_LO = 2;
  localparam int REG_IDX_W  = 4;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  localparam reg_idx_t REG_FIFO = 4'h0;
  localparam reg_idx_t REG_CTRL = 4'h1;

  // Status register bits, the rest read as zero
  localparam int STAT_RX_WAITING = 0;
  localparam int STAT_LINK_VALID = 1;

  typedef enum logic [1:0] {SEND_IDLE, SEND_FIRST, SEND_PAYLOAD} send_state_t;
  typedef enum logic {RECV_IDLE, RECV_FLIT} recv_state_t;

endpackage

//--- source/mpb_bus_regs.sv
////////////////////////////////////////////////////////////
// Bus register block
// Decodes AHB-Lite accesses, holds the enable bit and runs
// the send and receive state machines of the FIFO register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpb_bus_regs (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  mpb_bus_pkg::bus_req_t  bus_req,
  output mpb_bus_pkg::bus_data_t rdata,
  output logic                   ready,
  output logic                   resp,
  output mpb_noc_pkg::noc_flit_t tx_data,
  output logic                   tx_valid,
  input  logic                   tx_ready,
  input  mpb_noc_pkg::noc_flit_t rx_data,
  input  logic                   rx_valid,
  output logic                   rx_ready,
  input  mpb_noc_pkg::pkt_size_t rx_size,
  input  logic                   link_out_valid,
  output logic                   enabled
);

  import mpb_noc_pkg::*;
  import mpb_bus_pkg::*;

  reg_idx_t    reg_idx;
  logic        fifo_wr;
  logic        fifo_rd;
  logic        ctrl_acc;

  send_state_t send_state;
  send_state_t send_state_nxt;
  recv_state_t recv_state;
  recv_state_t recv_state_nxt;

  // Flits still to come in the packet being sent
  pkt_size_t   size_left;
  pkt_size_t   size_left_nxt;

  ////////////////////////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////////////////////////

  assign reg_idx  = bus_req.addr[REG_IDX_LO +: REG_IDX_W];
  assign fifo_wr  = bus_req.sel & (reg_idx == REG_FIFO) & bus_req.write;
  assign fifo_rd  = bus_req.sel & (reg_idx == REG_FIFO) & ~bus_req.write;
  assign ctrl_acc = bus_req.sel & (reg_idx == REG_CTRL);

  // Unmapped offsets answer with an error
  assign resp = bus_req.sel & (reg_idx != REG_FIFO) & (reg_idx != REG_CTRL);

  // Write data goes straight to the egress buffer
  assign tx_data.data = bus_req.wdata;
  assign tx_data.last = (size_left == pkt_size_t'(1));

  ////////////////////////////////////////////////////////////
  // Send and receive FSMs, read mux and stall
  ////////////////////////////////////////////////////////////

  always_comb begin
    ready          = 1'b1;
    rdata          = '0;
    tx_valid       = 1'b0;
    rx_ready       = 1'b0;
    send_state_nxt = send_state;
    size_left_nxt  = size_left;
    recv_state_nxt = recv_state;

    // Send side, first write is the flit count
    case (send_state)
      SEND_IDLE: begin
        if (fifo_wr && (bus_req.wdata[PKT_SIZE_W-1:0] != '0)) begin
          size_left_nxt  = bus_req.wdata[PKT_SIZE_W-1:0];
          send_state_nxt = SEND_FIRST;
        end
      end
      SEND_FIRST, SEND_PAYLOAD: begin
        if (fifo_wr) begin
          tx_valid = 1'b1;
          // Master stalls until the buffer takes the flit
          ready    = tx_ready;
          if (tx_ready) begin
            size_left_nxt  = size_left - 1'b1;
            send_state_nxt = tx_data.last ? SEND_IDLE : SEND_PAYLOAD;
          end
        end
      end
      default: begin
        send_state_nxt = SEND_IDLE;
      end
    endcase

    // Receive side, first read returns the count or zero
    case (recv_state)
      RECV_IDLE: begin
        if (fifo_rd) begin
          rdata = bus_data_t'(rx_size);
          if (rx_valid) begin
            recv_state_nxt = RECV_FLIT;
          end
        end
      end
      RECV_FLIT: begin
        if (fifo_rd) begin
          rdata    = rx_data.data;
          rx_ready = 1'b1;
          ready    = rx_valid;
          if (rx_valid && rx_data.last) begin
            recv_state_nxt = RECV_IDLE;
          end
        end
      end
      default: begin
        recv_state_nxt = RECV_IDLE;
      end
    endcase

    // Status read
    if (ctrl_acc && !bus_req.write) begin
      rdata[STAT_RX_WAITING] = rx_valid;
      rdata[STAT_LINK_VALID] = link_out_valid;
    end
  end

  always_ff @(posedge HCLK) begin
    if (HRESETn) begin
      send_state <= SEND_IDLE;
      recv_state <= RECV_IDLE;
      size_left  <= '0;
      enabled    <= 1'b0;
    end else begin
      send_state <= send_state_nxt;
      recv_state <= recv_state_nxt;
      size_left  <= size_left_nxt;
      // Any write to the control offset turns the end-point on
      if (ctrl_acc && bus_req.write) begin
        enabled <= 1'b1;
      end
    end
  end

endmodule

//--- source/mpb_control_responder.sv
////////////////////////////////////////////////////////////
// Control responder
// Answers single-flit control requests and merges the
// replies into the outgoing flit stream
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpb_control_responder (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   enabled,
  input  mpb_noc_pkg::noc_flit_t noc_in_data,
  input  logic                   noc_in_valid,
  output logic                   noc_in_ready,
  output mpb_noc_pkg::noc_flit_t rx_data,
  output logic                   rx_valid,
  input  logic                   rx_ready,
  input  mpb_noc_pkg::noc_flit_t tx_data,
  input  logic                   tx_valid,
  output logic                   tx_ready,
  output mpb_noc_pkg::noc_flit_t noc_out_data,
  output logic                   noc_out_valid,
  input  logic                   noc_out_ready
);

  import mpb_noc_pkg::*;

  flit_t reply_flit;
  logic  reply_pending;
  // Inside a multi-flit packet on either link
  logic  in_mid;
  logic  out_mid;
  logic  is_req;
  logic  send_reply;

  // Only a lone head flit of class 7 with bit 0 clear is a request
  assign is_req = noc_in_valid & ~in_mid & noc_in_data.last &
                  (noc_in_data.data[CTRL_CLASS_HI:CTRL_CLASS_LO] == CTRL_CLASS) &
                  ~noc_in_data.data[CTRL_REPLY_BIT];

  assign noc_in_ready = ~reply_pending & (is_req | rx_ready);
  assign rx_data      = noc_in_data;
  assign rx_valid     = noc_in_valid & ~reply_pending & ~is_req;

  // Packet mid-stream first, then the reply, then a new packet
  assign send_reply    = reply_pending & ~out_mid;
  assign noc_out_data  = send_reply ? noc_flit_t'{data: reply_flit, last: 1'b1} : tx_data;
  assign noc_out_valid = send_reply | tx_valid;
  assign tx_ready      = ~send_reply & noc_out_ready;

  // Reply word registered when the request is taken
  always_ff @(posedge HCLK) begin
    if (is_req && !reply_pending) begin
      reply_flit[CTRL_DST_HI:CTRL_DST_LO]         <= noc_in_data.data[CTRL_SRC_HI:CTRL_SRC_LO];
      reply_flit[CTRL_CLASS_HI:CTRL_CLASS_LO]     <= CTRL_CLASS;
      reply_flit[CTRL_SRC_HI:CTRL_SRC_LO]         <= noc_in_data.data[CTRL_DST_HI:CTRL_DST_LO];
      reply_flit[CTRL_PAYLOAD_HI:CTRL_PAYLOAD_LO] <=
        noc_in_data.data[CTRL_PAYLOAD_HI:CTRL_PAYLOAD_LO];
      reply_flit[CTRL_ENABLE_BIT]                 <= enabled;
      reply_flit[CTRL_REPLY_BIT]                  <= 1'b1;
    end
  end

  always_ff @(posedge HCLK) begin
    if (HRESETn) begin
      reply_pending <= 1'b0;
      in_mid        <= 1'b0;
      out_mid       <= 1'b0;
    end else begin
      if (is_req && !reply_pending) begin
        reply_pending <= 1'b1;
      end else if (send_reply && noc_out_ready) begin
        reply_pending <= 1'b0;
      end
      if (noc_in_valid && noc_in_ready) begin
        in_mid <= ~noc_in_data.last;
      end
      if (tx_valid && tx_ready) begin
        out_mid <= ~tx_data.last;
      end
    end
  end

endmodule

//--- source/mpb_endpoint.sv
////////////////////////////////////////////////////////////
// Message-passing end-point top level
// AHB-Lite slave on one side, mesh NoC link on the other
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpb_endpoint (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  logic                   HSEL,
  input  mpb_bus_pkg::bus_addr_t HADDR,
  input  logic                   HWRITE,
  input  mpb_bus_pkg::bus_data_t HWDATA,
  output mpb_bus_pkg::bus_data_t HRDATA,
  output logic                   HREADYOUT,
  output logic                   HRESP,
  input  mpb_noc_pkg::flit_t     noc_in_flit,
  input  logic                   noc_in_last,
  input  logic                   noc_in_valid,
  output logic                   noc_in_ready,
  output mpb_noc_pkg::flit_t     noc_out_flit,
  output logic                   noc_out_last,
  output logic                   noc_out_valid,
  input  logic                   noc_out_ready
);

  import mpb_noc_pkg::*;
  import mpb_bus_pkg::*;

  bus_req_t  bus_req;
  logic      enabled;

  // Egress path, registers to buffer to responder
  noc_flit_t tx_in;
  logic      tx_in_valid;
  logic      tx_in_ready;
  noc_flit_t tx_out;
  logic      tx_out_valid;
  logic      tx_out_ready;

  // Ingress path, responder to buffer to registers
  noc_flit_t rx_in;
  logic      rx_in_valid;
  logic      rx_in_ready;
  noc_flit_t rx_out;
  logic      rx_out_valid;
  logic      rx_out_ready;
  pkt_size_t rx_size;

  noc_flit_t noc_in;
  noc_flit_t noc_out;

  assign bus_req      = '{sel: HSEL, write: HWRITE, addr: HADDR, wdata: HWDATA};
  assign noc_in       = '{data: noc_in_flit, last: noc_in_last};
  assign noc_out_flit = noc_out.data;
  assign noc_out_last = noc_out.last;

  mpb_bus_regs regs (
    .HCLK           (HCLK),
    .HRESETn        (HRESETn),
    .bus_req        (bus_req),
    .rdata          (HRDATA),
    .ready          (HREADYOUT),
    .resp           (HRESP),
    .tx_data        (tx_in),
    .tx_valid       (tx_in_valid),
    .tx_ready       (tx_in_ready),
    .rx_data        (rx_out),
    .rx_valid       (rx_out_valid),
    .rx_ready       (rx_out_ready),
    .rx_size        (rx_size),
    .link_out_valid (noc_out_valid),
    .enabled        (enabled)
  );

  // Egress packet size is not needed on the link side
  mpb_packet_buffer tx_buffer (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .in_data     (tx_in),
    .in_valid    (tx_in_valid),
    .in_ready    (tx_in_ready),
    .out_data    (tx_out),
    .out_valid   (tx_out_valid),
    .out_ready   (tx_out_ready),
    .packet_size ()
  );

  mpb_packet_buffer rx_buffer (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .in_data     (rx_in),
    .in_valid    (rx_in_valid),
    .in_ready    (rx_in_ready),
    .out_data    (rx_out),
    .out_valid   (rx_out_valid),
    .out_ready   (rx_out_ready),
    .packet_size (rx_size)
  );

  mpb_control_responder responder (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .enabled       (enabled),
    .noc_in_data   (noc_in),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .rx_data       (rx_in),
    .rx_valid      (rx_in_valid),
    .rx_ready      (rx_in_ready),
    .tx_data       (tx_out),
    .tx_valid      (tx_out_valid),
    .tx_ready      (tx_out_ready),
    .noc_out_data  (noc_out),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

endmodule

//--- source/mpb_noc_pkg.sv
////////////////////////////////////////////////////////////
// Message-passing end-point, network side definitions
// Flit format, control-message fields and buffer sizing
////////////////////////////////////////////////////////////

package mpb_noc_pkg;

  // One flit on the mesh link
  typedef logic [31:0] flit_t;

  // Flit with its end-of-packet marker
  typedef struct packed {
    flit_t data;
    logic  last;
  } noc_flit_t;

  // Flits per packet buffer, also the largest packet
  localparam int BUF_DEPTH  = 16;
  localparam int PTR_W      = $clog2(BUF_DEPTH);
  localparam int PKT_SIZE_W = $clog2(BUF_DEPTH + 1);

  typedef logic [PTR_W-1:0]      buf_ptr_t;
  typedef logic [PKT_SIZE_W-1:0] pkt_size_t;

  // Control message fields
  localparam int CTRL_DST_HI     = 31;
  localparam int CTRL_DST_LO     = 27;
  localparam int CTRL_CLASS_HI   = 26;
  localparam int CTRL_CLASS_LO   = 24;
  localparam int CTRL_SRC_HI     = 23;
  localparam int CTRL_SRC_LO     = 19;
  localparam int CTRL_PAYLOAD_HI = 18;
  localparam int CTRL_PAYLOAD_LO = 2;
  localparam int CTRL_ENABLE_BIT = 1;
  localparam int CTRL_REPLY_BIT  = 0;

  localparam logic [2:0] CTRL_CLASS = 3'd7;

endpackage

//--- source/mpb_packet_buffer.sv
////////////////////////////////////////////////////////////
// Full-packet FIFO
// Releases a packet only after its last flit is stored and
// reports the flit count of the packet at its head
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpb_packet_buffer (
  input  logic                   HCLK,
  input  logic                   HRESETn,
  input  mpb_noc_pkg::noc_flit_t in_data,
  input  logic                   in_valid,
  output logic                   in_ready,
  output mpb_noc_pkg::noc_flit_t out_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output mpb_noc_pkg::pkt_size_t packet_size
);

  import mpb_noc_pkg::*;

  // Flit storage and per-packet length queue
  noc_flit_t mem [BUF_DEPTH];
  pkt_size_t len_mem [BUF_DEPTH];

  buf_ptr_t  wr_ptr;
  buf_ptr_t  rd_ptr;
  buf_ptr_t  len_wr_ptr;
  buf_ptr_t  len_rd_ptr;

  // Stored flits and complete packets
  pkt_size_t fill;
  pkt_size_t pkt_count;
  // Flits of the packet currently coming in
  pkt_size_t in_len;

  logic push;
  logic pop;
  logic push_last;
  logic pop_last;

  assign in_ready  = (fill != pkt_size_t'(BUF_DEPTH));
  assign out_valid = (pkt_count != '0);

  // Stale end marker hidden while no packet is waiting
  assign out_data.data = mem[rd_ptr].data;
  assign out_data.last = mem[rd_ptr].last & out_valid;

  // Head length only means something while a packet is waiting
  assign packet_size = out_valid ? len_mem[len_rd_ptr] : '0;

  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;
  assign push_last = push & in_data.last;
  assign pop_last  = pop & out_data.last;

  ////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
    if (push_last) begin
      len_mem[len_wr_ptr] <= in_len + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Pointers and counters
  ////////////////////////////////////////////////////////////

  always_ff @(posedge HCLK) begin
    if (HRESETn) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      len_wr_ptr <= '0;
      len_rd_ptr <= '0;
      fill       <= '0;
      pkt_count  <= '0;
      in_len     <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
        // Restart length count at each packet boundary
        in_len <= in_data.last ? '0 : in_len + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_last) begin
        len_wr_ptr <= len_wr_ptr + 1'b1;
      end
      if (pop_last) begin
        len_rd_ptr <= len_rd_ptr + 1'b1;
      end
      // Simultaneous push and pop leave the counts alone
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
      if (push_last && !pop_last) begin
        pkt_count <= pkt_count + 1'b1;
      end else if (pop_last && !push_last) begin
        pkt_count <= pkt_count - 1'b1;
      end
    end
  end

endmodule

//--- verif/mpb_endpoint_properties.sv
////////////////////////////////////////////////////////////
// End-point interface assertions
// Bus error response and outgoing link protocol
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpb_endpoint_properties (
  input logic               HCLK,
  input logic               HRESETn,
  input logic               HSEL,
  input logic               HRESP,
  input mpb_noc_pkg::flit_t noc_out_flit,
  input logic               noc_out_last,
  input logic               noc_out_valid,
  input logic               noc_out_ready
);

  // Failure tally, read by the testbench at the end
  int assert_errors = 0;

  // Error response only on a selected access
  resp_needs_sel: assert property (@(posedge HCLK) HRESP |-> HSEL)
    else begin
      assert_errors++;
      $error("HRESP high while HSEL low");
    end

  // End marker only together with a valid flit
  last_needs_valid: assert property (@(posedge HCLK) disable iff (HRESETn)
    noc_out_last |-> noc_out_valid)
    else begin
      assert_errors++;
      $error("noc_out_last high while noc_out_valid low");
    end

  // Stalled flit stays put
  flit_held: assert property (@(posedge HCLK) disable iff (HRESETn)
    (noc_out_valid && !noc_out_ready) |=> $stable(noc_out_flit))
    else begin
      assert_errors++;
      $error("noc_out_flit changed while stalled");
    end

  // Nothing on the link right after a reset cycle
  idle_after_reset: assert property (@(posedge HCLK) HRESETn |=> !noc_out_valid)
    else begin
      assert_errors++;
      $error("noc_out_valid high after reset");
    end

endmodule

//--- verif/mpb_endpoint_tb.sv
////////////////////////////////////////////////////////////
// Message-passing end-point testbench
// Directed tests of registers, send, receive, control
// replies and egress back-pressure
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module mpb_endpoint_tb;

  import mpb_noc_pkg::*;
  import mpb_bus_pkg::*;

  localparam int        TIMEOUT   = 200;
  localparam bus_addr_t ADDR_FIFO = 32'h0;
  localparam bus_addr_t ADDR_CTRL = 32'h4;
  localparam bus_addr_t ADDR_BAD  = 32'h8;

  logic      HCLK;
  logic      HRESETn;
  logic      HSEL;
  bus_addr_t HADDR;
  logic      HWRITE;
  bus_data_t HWDATA;
  bus_data_t HRDATA;
  logic      HREADYOUT;
  logic      HRESP;
  flit_t     noc_in_flit;
  logic      noc_in_last;
  logic      noc_in_valid;
  logic      noc_in_ready;
  flit_t     noc_out_flit;
  logic      noc_out_last;
  logic      noc_out_valid;
  logic      noc_out_ready;

  integer seed;
  int     errors;
  int     tests;
  int     failed_tests;

  // Expected flits in order, and flits seen on noc_out
  flit_t  sent_q[$];
  flit_t  got_q[$];
  logic   last_q[$];

  mpb_endpoint dut0 (.*);

  bind mpb_endpoint mpb_endpoint_properties props0 (
    .HCLK          (HCLK),
    .HRESETn       (HRESETn),
    .HSEL          (HSEL),
    .HRESP         (HRESP),
    .noc_out_flit  (noc_out_flit),
    .noc_out_last  (noc_out_last),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready)
  );

  initial HCLK = 1'b0;
  always #4 HCLK = ~HCLK;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("ERROR %s got %h expected %h", name, got, exp);
    errors++;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests++;
    if (errors == errs_before) begin
      $display("Test %s passed", name);
    end else begin
      $display("Test %s failed with %0d errors", name, errors - errs_before);
      failed_tests++;
    end
  endtask

  // Reply swaps source and destination and copies the payload
  function automatic flit_t make_reply(input flit_t req, input logic en);
    return {req[23:19], 3'd7, req[31:27], req[18:2], en, 1'b1};
  endfunction

  // One AHB-Lite transfer held until HREADYOUT
  task automatic bus_access(input logic write, input bus_addr_t addr,
                            input bus_data_t wdata, output bus_data_t rdata,
                            output logic resp);
    int wait_cnt;
    wait_cnt = 0;
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = addr;
    HWRITE = write;
    HWDATA = wdata;
    #1;
    while (!HREADYOUT && wait_cnt < TIMEOUT) begin
      @(negedge HCLK);
      #1;
      wait_cnt++;
    end
    if (!HREADYOUT) begin
      $display("Bus access to address %h never completed", addr);
      errors++;
    end
    rdata = HRDATA;
    resp  = HRESP;
    @(posedge HCLK);
    @(negedge HCLK);
    HSEL = 1'b0;
  endtask

  task automatic bus_write(input bus_addr_t addr, input bus_data_t wdata,
                           output logic resp);
    bus_data_t unused;
    bus_access(1'b1, addr, wdata, unused, resp);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t rdata,
                          output logic resp);
    bus_access(1'b0, addr, 32'h0, rdata, resp);
  endtask

  // Size word then the flits through offset 0x0
  task automatic write_packet(input int n);
    flit_t flit;
    logic  resp;
    bus_write(ADDR_FIFO, n, resp);
    for (int i = 0; i < n; i++) begin
      flit = $random(seed);
      sent_q.push_back(flit);
      bus_write(ADDR_FIFO, flit, resp);
    end
  endtask

  // One flit into noc_in after a random idle gap
  task automatic drive_flit(input flit_t flit, input logic last);
    int wait_cnt;
    int gap;
    wait_cnt = 0;
    @(negedge HCLK);
    gap = $unsigned($random(seed)) % 3;
    if (gap != 0) begin
      noc_in_valid = 1'b0;
      repeat (gap) @(negedge HCLK);
    end
    noc_in_flit  = flit;
    noc_in_last  = last;
    noc_in_valid = 1'b1;
    #1;
    while (!noc_in_ready && wait_cnt < TIMEOUT) begin
      @(negedge HCLK);
      #1;
      wait_cnt++;
    end
    if (!noc_in_ready) begin
      $display("Link input never accepted flit %h", flit);
      errors++;
    end
    @(posedge HCLK);
  endtask

  task automatic send_packet(input int n);
    flit_t flit;
    for (int i = 0; i < n; i++) begin
      flit = $random(seed);
      // Keep the class field off the control value
      flit[26] = 1'b0;
      sent_q.push_back(flit);
      drive_flit(flit, i == n - 1);
    end
    @(negedge HCLK);
    noc_in_valid = 1'b0;
  endtask

  // Gather n flits from noc_out under random ready
  task automatic collect_packet(input int n);
    int wait_cnt;
    wait_cnt = 0;
    got_q.delete();
    last_q.delete();
    while (got_q.size() < n && wait_cnt < TIMEOUT) begin
      @(negedge HCLK);
      noc_out_ready = ($random(seed) % 2) != 0;
      #1;
      if (noc_out_valid && noc_out_ready) begin
        got_q.push_back(noc_out_flit);
        last_q.push_back(noc_out_last);
        wait_cnt = 0;
      end else begin
        wait_cnt++;
      end
      @(posedge HCLK);
    end
    if (got_q.size() < n) begin
      $display("Link output gave %0d of %0d flits before timeout", got_q.size(), n);
      errors++;
    end
    @(negedge HCLK);
    noc_out_ready = 1'b0;
  endtask

  // Compare collected flits with the oldest expected ones
  task automatic check_packet(input int n);
    flit_t exp;
    for (int i = 0; i < n; i++) begin
      exp = sent_q.pop_front();
      if (i < got_q.size()) begin
        if (got_q[i] !== exp) begin
          report_mismatch("noc_out_flit", got_q[i], exp);
        end
        if (last_q[i] !== (i == n - 1)) begin
          report_mismatch("noc_out_last", last_q[i], i == n - 1);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////

  task automatic test_registers();
    int        errs;
    bus_data_t rd;
    logic      resp;
    errs = errors;
    bus_read(ADDR_CTRL, rd, resp);
    if (rd !== 32'h0) report_mismatch("HRDATA", rd, 32'h0);
    if (resp !== 1'b0) report_mismatch("HRESP", resp, 1'b0);
    // Unmapped offset answers with an error both ways
    bus_read(ADDR_BAD, rd, resp);
    if (resp !== 1'b1) report_mismatch("HRESP", resp, 1'b1);
    bus_write(ADDR_BAD, 32'h1234_5678, resp);
    if (resp !== 1'b1) report_mismatch("HRESP", resp, 1'b1);
    finish_test("registers", errs);
  endtask

  task automatic test_control();
    int        errs;
    flit_t     req;
    bus_data_t rd;
    logic      resp;
    errs = errors;
    for (int round = 0; round < 2; round++) begin
      if (round == 1) begin
        // Second request sees the end-point enabled
        bus_write(ADDR_CTRL, 32'h1, resp);
        if (resp !== 1'b0) report_mismatch("HRESP", resp, 1'b0);
      end
      req        = $random(seed);
      req[26:24] = 3'd7;
      req[0]     = 1'b0;
      drive_flit(req, 1'b1);
      @(negedge HCLK);
      noc_in_valid = 1'b0;
      // Link input stays closed while the reply is pending
      #1;
      if (noc_in_ready !== 1'b0) report_mismatch("noc_in_ready", noc_in_ready, 1'b0);
      collect_packet(1);
      if (got_q.size() == 1) begin
        if (got_q[0] !== make_reply(req, round == 1)) begin
          report_mismatch("noc_out_flit", got_q[0], make_reply(req, round == 1));
        end
        if (last_q[0] !== 1'b1) report_mismatch("noc_out_last", last_q[0], 1'b1);
      end
      // Request never lands in the receive buffer
      bus_read(ADDR_CTRL, rd, resp);
      if (rd[0] !== 1'b0) report_mismatch("HRDATA[0]", rd[0], 1'b0);
    end
    bus_read(ADDR_FIFO, rd, resp);
    if (rd !== 32'h0) report_mismatch("HRDATA", rd, 32'h0);
    finish_test("control", errs);
  endtask

  task automatic test_send();
    int        errs;
    int        sizes[3] = '{1, 7, 16};
    bus_data_t rd;
    logic      resp;
    errs = errors;
    foreach (sizes[k]) begin
      write_packet(sizes[k]);
      // Packet waits on the link while ready is low
      bus_read(ADDR_CTRL, rd, resp);
      if (rd[1] !== 1'b1) report_mismatch("HRDATA[1]", rd[1], 1'b1);
      collect_packet(sizes[k]);
      check_packet(sizes[k]);
    end
    finish_test("send", errs);
  endtask

  task automatic test_receive();
    int        errs;
    int        sizes[2] = '{1, 6};
    flit_t     exp;
    bus_data_t rd;
    logic      resp;
    errs = errors;
    bus_read(ADDR_FIFO, rd, resp);
    if (rd !== 32'h0) report_mismatch("HRDATA", rd, 32'h0);
    foreach (sizes[k]) begin
      send_packet(sizes[k]);
      bus_read(ADDR_CTRL, rd, resp);
      if (rd[0] !== 1'b1) report_mismatch("HRDATA[0]", rd[0], 1'b1);
      bus_read(ADDR_FIFO, rd, resp);
      if (rd !== sizes[k]) report_mismatch("HRDATA", rd, sizes[k]);
      for (int i = 0; i < sizes[k]; i++) begin
        exp = sent_q.pop_front();
        bus_read(ADDR_FIFO, rd, resp);
        if (rd !== exp) report_mismatch("HRDATA", rd, exp);
      end
    end
    finish_test("receive", errs);
  endtask

  task automatic test_backpressure();
    int    errs;
    flit_t flit;
    logic  resp;
    errs = errors;
    // Fill the egress buffer with the link stalled
    write_packet(BUF_DEPTH);
    bus_write(ADDR_FIFO, 32'h1, resp);
    flit = $random(seed);
    sent_q.push_back(flit);
    @(negedge HCLK);
    HSEL   = 1'b1;
    HADDR  = ADDR_FIFO;
    HWRITE = 1'b1;
    HWDATA = flit;
    repeat (4) begin
      #1;
      if (HREADYOUT !== 1'b0) report_mismatch("HREADYOUT", HREADYOUT, 1'b0);
      @(negedge HCLK);
    end
    // Draining the link lets the held write through
    fork
      bus_write(ADDR_FIFO, flit, resp);
      collect_packet(BUF_DEPTH);
    join
    check_packet(BUF_DEPTH);
    collect_packet(1);
    check_packet(1);
    finish_test("backpressure", errs);
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    seed          = 32'h07459238;
    errors        = 0;
    tests         = 0;
    failed_tests  = 0;
    HRESETn       = 1'b1;
    HSEL          = 1'b0;
    HADDR         = '0;
    HWRITE        = 1'b0;
    HWDATA        = '0;
    noc_in_flit   = '0;
    noc_in_last   = 1'b0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b0;
    repeat (3) @(posedge HCLK);
    @(negedge HCLK);
    HRESETn = 1'b0;

    test_registers();
    test_control();
    test_send();
    test_receive();
    test_backpressure();

    if (dut0.props0.assert_errors != 0) begin
      $display("Assertions failed %0d times", dut0.props0.assert_errors);
      errors += dut0.props0.assert_errors;
    end
    $display("Tests run %0d, tests failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/mpb_noc_pkg.sv
source/mpb_bus_pkg.sv
source/mpb_packet_buffer.sv
source/mpb_bus_regs.sv
source/mpb_control_responder.sv
source/mpb_endpoint.sv
verif/mpb_endpoint_properties.sv
verif/mpb_endpoint_tb.sv
